//--- build.f
cpu_pkg.sv
mul_unit.sv
div_unit.sv
multi_cycle_exec.sv
hilo_reg.sv
exec_top.sv
tb_exec.sv

//--- cpu_pkg.sv
package cpu_pkg;

	// Register word.
	typedef logic [31:0] uint32_t;

	// HI in the upper half, LO in the lower half.
	typedef logic [63:0] uint64_t;

	// Operations known to the execute stage.
	typedef enum logic [5:0] {
		OP_SLL,
		OP_MADD,
		OP_MADDU,
		OP_MSUB,
		OP_MSUBU,
		OP_MUL,
		OP_MULT,
		OP_MULTU,
		OP_DIV,
		OP_DIVU,
		OP_MFHI,
		OP_MFLO,
		OP_MTHI,
		OP_MTLO
	} oper_t;

	// Decoder output for one slot.
	typedef struct packed {
		oper_t op;
		logic  is_multicyc;
	} decoded_instr_t;

	// Decoded instruction with its register operands.
	typedef struct packed {
		decoded_instr_t decoded;
		uint32_t        reg1;
		uint32_t        reg2;
	} pipeline_decode_t;

endpackage

//--- div_unit.sv
`timescale 1ns/1ps

module div_unit #(
	parameter int DIV_BITS = 1
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  cpu_pkg::uint32_t dividend,
	input  cpu_pkg::uint32_t divisor,
	output cpu_pkg::uint32_t quotient,
	output cpu_pkg::uint32_t remainder,
	output logic             done
);
	import cpu_pkg::*;

	localparam int STEPS = 32 / DIV_BITS;

	uint32_t rem_q;
	uint32_t quo_q;
	uint32_t den_q;
	uint32_t rem_d;
	uint32_t quo_d;
	logic [5:0] count;
	logic busy;

	// Restoring steps, dividend bits shift out as quotient bits shift in.
	always_comb begin
		logic [32:0] trial;
		logic fits;
		rem_d = rem_q;
		quo_d = quo_q;
		for (int i = 0; i < DIV_BITS; i++) begin
			trial = {rem_d, quo_d[31]};
			fits = trial >= {1'b0, den_q};
			if (fits) begin
				trial = trial - {1'b0, den_q};
			end
			rem_d = trial[31:0];
			quo_d = {quo_d[30:0], fits};
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			rem_q <= '0;
			quo_q <= dividend;
			den_q <= divisor;
		end else if (busy) begin
			rem_q <= rem_d;
			quo_q <= quo_d;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			count <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 6'd1;
				if (count == 6'(STEPS - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	assign quotient  = quo_q;
	assign remainder = rem_q;

	// The execute unit must not restart a division in flight.
	a_no_start_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

//--- exec_top.sv
`timescale 1ns/1ps

module exec_top #(
	parameter int DIV_BITS = 1
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            stall,
	input  logic                            flush,
	input  cpu_pkg::pipeline_decode_t [1:0] request,
	output logic                            stall_req,
	output cpu_pkg::uint32_t                reg_o,
	output cpu_pkg::uint64_t                hilo
);
	import cpu_pkg::*;

	uint64_t hilo_next;
	logic commit;

	multi_cycle_exec #(
		.DIV_BITS(DIV_BITS)
	) multi_cycle_exec_i (
		.clk      (clk),
		.rst      (rst),
		.stall    (stall),
		.flush    (flush),
		.request  (request),
		.stall_req(stall_req),
		.hilo_cur (hilo),
		.hilo_next(hilo_next),
		.reg_o    (reg_o),
		.commit   (commit)
	);

	hilo_reg hilo_reg_i (
		.clk      (clk),
		.rst      (rst),
		.commit   (commit),
		.hilo_next(hilo_next),
		.hilo     (hilo)
	);

endmodule

//--- hilo_reg.sv
`timescale 1ns/1ps

module hilo_reg (
	input  logic             clk,
	input  logic             rst,
	input  logic             commit,
	input  cpu_pkg::uint64_t hilo_next,
	output cpu_pkg::uint64_t hilo
);

	// Architectural HI/LO pair.
	always_ff @(posedge clk) begin
		if (rst) begin
			hilo <= '0;
		end else if (commit) begin
			hilo <= hilo_next;
		end
	end

endmodule

//--- mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
	input  logic             clk,
	input  logic             rst,
	input  cpu_pkg::uint32_t a,
	input  cpu_pkg::uint32_t b,
	output cpu_pkg::uint64_t product
);
	import cpu_pkg::*;

	uint32_t pp_hh;
	uint32_t pp_hl;
	uint32_t pp_lh;
	uint32_t pp_ll;

	// Stage one, four 16x16 partial products.
	always_ff @(posedge clk) begin
		if (rst) begin
			pp_hh <= '0;
			pp_hl <= '0;
			pp_lh <= '0;
			pp_ll <= '0;
		end else begin
			pp_hh <= 32'(a[31:16]) * 32'(b[31:16]);
			pp_hl <= 32'(a[31:16]) * 32'(b[15:0]);
			pp_lh <= 32'(a[15:0]) * 32'(b[31:16]);
			pp_ll <= 32'(a[15:0]) * 32'(b[15:0]);
		end
	end

	// Stage two, middle terms line up at bit 16.
	always_ff @(posedge clk) begin
		if (rst) begin
			product <= '0;
		end else begin
			product <= {pp_hh, pp_ll} + (64'(pp_hl) << 16) + (64'(pp_lh) << 16);
		end
	end

endmodule

//--- multi_cycle_exec.sv
`timescale 1ns/1ps

module multi_cycle_exec #(
	parameter int DIV_BITS = 1
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            stall,
	input  logic                            flush,
	input  cpu_pkg::pipeline_decode_t [1:0] request,
	output logic                            stall_req,
	input  cpu_pkg::uint64_t                hilo_cur,
	output cpu_pkg::uint64_t                hilo_next,
	output cpu_pkg::uint32_t                reg_o,
	output logic                            commit
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		FINISH
	} state_t;

	state_t state, state_d;
	pipeline_decode_t sel;
	oper_t op;
	logic [1:0] is_multicyc;
	logic [1:0] cyc_cnt;
	logic accept, data_ready, div_start, div_done, op_div, negate;
	uint32_t reg1, reg2, abs_a, abs_b, sel_abs1, sel_abs2;
	uint32_t abs_quo, abs_rem, div_quo, div_rem, reg_ret;
	uint64_t hilo_cap, product, mul_result, hilo_ret;

	function automatic logic signed_op(oper_t o);
		return o inside {OP_MADD, OP_MSUB, OP_MUL, OP_MULT, OP_DIV};
	endfunction

	// Slot 1 has priority.
	assign is_multicyc = {request[1].decoded.is_multicyc, request[0].decoded.is_multicyc};
	assign sel = is_multicyc[1] ? request[1] : request[0];
	assign sel_abs1 = (signed_op(sel.decoded.op) && sel.reg1[31]) ? -sel.reg1 : sel.reg1;
	assign sel_abs2 = (signed_op(sel.decoded.op) && sel.reg2[31]) ? -sel.reg2 : sel.reg2;

	assign accept    = state == IDLE && |is_multicyc && !flush;
	assign div_start = accept && sel.decoded.op inside {OP_DIV, OP_DIVU};
	assign stall_req = !((state == IDLE && !(|is_multicyc)) || state == FINISH);
	assign commit    = state == FINISH && !stall && !flush;

	always_comb begin
		state_d = state;
		unique case (state)
			IDLE:   if (|is_multicyc) state_d = WAIT;
			WAIT:   if (data_ready) state_d = FINISH;
			FINISH: if (!stall) state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= IDLE;
		end else begin
			state <= state_d;
		end
	end

	// Operands and HI/LO captured at acceptance.
	always_ff @(posedge clk) begin
		if (rst) begin
			op <= OP_SLL;
		end else if (accept) begin
			op <= sel.decoded.op;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			reg1     <= sel.reg1;
			reg2     <= sel.reg2;
			abs_a    <= sel_abs1;
			abs_b    <= sel_abs2;
			hilo_cap <= hilo_cur;
		end
	end

	// Two multiplier stages plus the final add.
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			cyc_cnt <= '0;
		end else if (accept) begin
			cyc_cnt <= (sel.decoded.op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
				OP_MUL, OP_MULT, OP_MULTU}) ? 2'd2 : 2'd0;
		end else if (state == WAIT && cyc_cnt != '0) begin
			cyc_cnt <= cyc_cnt - 2'd1;
		end
	end

	assign op_div     = op inside {OP_DIV, OP_DIVU};
	assign data_ready = op_div ? div_done : (cyc_cnt == '0);

	mul_unit mul_unit_i (
		.clk    (clk),
		.rst    (rst),
		.a      (abs_a),
		.b      (abs_b),
		.product(product)
	);

	div_unit #(
		.DIV_BITS(DIV_BITS)
	) div_unit_i (
		.clk      (clk),
		.rst      (rst || flush),
		.start    (div_start),
		.dividend (sel_abs1),
		.divisor  (sel_abs2),
		.quotient (abs_quo),
		.remainder(abs_rem),
		.done     (div_done)
	);

	// Remainder follows the dividend sign.
	assign negate     = signed_op(op) && (reg1[31] ^ reg2[31]);
	assign mul_result = negate ? -product : product;
	assign div_quo    = negate ? -abs_quo : abs_quo;
	assign div_rem    = (signed_op(op) && reg1[31]) ? -abs_rem : abs_rem;

	always_comb begin
		case (op)
			OP_MADD, OP_MADDU: hilo_ret = hilo_cap + mul_result;
			OP_MSUB, OP_MSUBU: hilo_ret = hilo_cap - mul_result;
			OP_MULT, OP_MULTU: hilo_ret = mul_result;
			OP_DIV, OP_DIVU:   hilo_ret = {div_rem, div_quo};
			OP_MTHI:           hilo_ret = {reg1, hilo_cap[31:0]};
			OP_MTLO:           hilo_ret = {hilo_cap[63:32], reg1};
			default:           hilo_ret = hilo_cap;
		endcase
	end

	always_comb begin
		case (op)
			OP_MUL:  reg_ret = mul_result[31:0];
			OP_MFHI: reg_ret = hilo_cap[63:32];
			OP_MFLO: reg_ret = hilo_cap[31:0];
			default: reg_ret = '0;
		endcase
	end

	// Held through FINISH.
	always_ff @(posedge clk) begin
		if (rst) begin
			hilo_next <= '0;
			reg_o     <= '0;
		end else if (state == WAIT && data_ready) begin
			hilo_next <= hilo_ret;
			reg_o     <= reg_ret;
		end
	end

	// Back-pressure keeps the result steady.
	a_finish_hold: assert property (@(posedge clk) disable iff (rst || flush)
		(state == FINISH && stall) |=>
			(state == FINISH) && $stable(hilo_next) && $stable(reg_o));

	// Fixed-length operations leave WAIT within three cycles.
	a_wait_bounded: assert property (@(posedge clk) disable iff (rst || flush)
		(state == WAIT && !op_div) |-> ##[0:2] data_ready);

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the execute unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_exec -f build.f -o tb_exec; then
	echo "Verilator compile failed"
	exit 1
fi

if ! ./obj_dir/tb_exec > sim.log 2>&1; then
	cat sim.log
	echo "Simulation run failed"
	exit 1
fi
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
	exit 0
fi
exit 1

//--- tb_exec.sv
`timescale 1ns/1ps

module tb_exec;
	import cpu_pkg::*;

	localparam int DIV_BITS = 2;
	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS = 6;
	localparam int OPS_PER_TEST = 30;
	localparam int OP_CYCLES = 32 / DIV_BITS + 20;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * OPS_PER_TEST * OP_CYCLES + 100;

	logic clk;
	logic rst;
	logic stall;
	logic flush;
	pipeline_decode_t [1:0] request;
	logic stall_req;
	uint32_t reg_o;
	uint64_t hilo;

	// Reference state and the operation in flight.
	pipeline_decode_t cur;
	logic pending;
	uint64_t model_hilo;
	uint64_t hilo_prev;
	uint32_t model_reg;
	int errors;
	logic in_finish;
	logic commit_now;
	logic reg_due;

	// Grouped so that each test draws from a contiguous range.
	oper_t ops [13] = '{OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU, OP_MUL,
		OP_DIV, OP_DIVU, OP_MTHI, OP_MTLO, OP_MFHI, OP_MFLO};

	exec_top #(.DIV_BITS(DIV_BITS)) exec_top_i (.*);

	assign in_finish  = pending && !stall_req;
	assign commit_now = in_finish && !stall && !flush;
	assign reg_due    = cur.decoded.op inside {OP_MUL, OP_MFHI, OP_MFLO};

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) hilo_prev <= hilo;

	function automatic uint64_t full_product(input pipeline_decode_t s);
		logic sgn;
		uint64_t a;
		uint64_t b;
		sgn = s.decoded.op inside {OP_MULT, OP_MUL, OP_MADD, OP_MSUB};
		a = sgn ? {{32{s.reg1[31]}}, s.reg1} : {32'd0, s.reg1};
		b = sgn ? {{32{s.reg2[31]}}, s.reg2} : {32'd0, s.reg2};
		return a * b;
	endfunction

	// Division truncates toward zero and the remainder keeps the dividend's sign.
	function automatic uint64_t next_hilo(input pipeline_decode_t s, input uint64_t m);
		case (s.decoded.op)
			OP_MULT, OP_MULTU: return full_product(s);
			OP_MADD, OP_MADDU: return m + full_product(s);
			OP_MSUB, OP_MSUBU: return m - full_product(s);
			OP_DIV: begin
				return {32'($signed(s.reg1) % $signed(s.reg2)),
					32'($signed(s.reg1) / $signed(s.reg2))};
			end
			OP_DIVU: return {s.reg1 % s.reg2, s.reg1 / s.reg2};
			OP_MTHI: return {s.reg1, m[31:0]};
			OP_MTLO: return {m[63:32], s.reg1};
			default: return m;
		endcase
	endfunction

	function automatic pipeline_decode_t make_slot(input oper_t op, input logic multi);
		pipeline_decode_t s;
		s.decoded.op = op;
		s.decoded.is_multicyc = multi;
		s.reg1 = $urandom;
		s.reg2 = $urandom;
		if (op inside {OP_DIV, OP_DIVU} && s.reg2 == '0) begin
			s.reg2 = 32'd1;
		end
		// Signed overflow has no defined quotient.
		if (op == OP_DIV && s.reg1 == 32'h8000_0000 && s.reg2 == '1) begin
			s.reg2 = 32'd3;
		end
		return s;
	endfunction

	task automatic run_op(input pipeline_decode_t win, input pipeline_decode_t other,
		input logic slot, input int hold, input int flush_at);
		int edges;
		int held;
		uint64_t prod;
		oper_t op;
		edges = 0;
		held = 0;
		op = win.decoded.op;
		@(posedge clk);
		request[slot] <= win;
		request[!slot] <= other;
		cur <= win;
		pending <= 1'b1;
		stall <= hold > 0;
		forever begin
			@(posedge clk);
			edges++;
			if (flush || commit_now || edges > OP_CYCLES) begin
				if (commit_now) begin
					prod = full_product(cur);
					model_hilo <= next_hilo(cur, model_hilo);
					model_reg <= op == OP_MFHI ? model_hilo[63:32] :
						op == OP_MFLO ? model_hilo[31:0] : prod[31:0];
				end else if (!flush) begin
					errors++;
					$display("Operation %s did not complete within %0d cycles",
						op.name(), OP_CYCLES);
				end
				request <= '0;
				pending <= 1'b0;
				stall <= 1'b0;
				flush <= 1'b0;
				break;
			end
			if (edges == flush_at) begin
				flush <= 1'b1;
			end
			// Either random back-pressure or a fixed number of stalled FINISH cycles.
			if (hold == 0) begin
				stall <= $urandom_range(0, 3) == 0;
			end else if (in_finish) begin
				held++;
				if (held >= hold) begin
					stall <= 1'b0;
				end
			end
		end
	endtask

	task automatic run_test(input string name, input int first, input int count,
		input int mode);
		int base;
		pipeline_decode_t win;
		pipeline_decode_t other;
		logic slot;
		int hold;
		int flush_at;
		base = errors;
		for (int i = 0; i < OPS_PER_TEST; i++) begin
			win = make_slot(ops[first + $urandom_range(0, count - 1)], 1'b1);
			other = $urandom_range(0, 1) == 1 ? make_slot(OP_SLL, 1'b0) : '0;
			slot = $urandom_range(0, 1) == 1;
			hold = 0;
			flush_at = 0;
			if (mode == 1) begin
				other = make_slot(ops[$urandom_range(0, 12)], 1'b1);
				slot = 1'b1;
			end else if (mode == 2 && i % 2 == 0) begin
				win = make_slot($urandom_range(0, 1) == 1 ? OP_DIV : OP_DIVU, 1'b1);
				flush_at = $urandom_range(1, 6);
			end else if (mode == 2) begin
				hold = $urandom_range(1, 4);
			end
			run_op(win, other, slot, hold, flush_at);
		end
		$display("test %s: %0d operations, %0d errors", name, OPS_PER_TEST, errors - base);
	endtask

	initial begin
		void'($urandom(32'h9da0_4e09));
		rst = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		request = '0;
		cur = '0;
		pending = 1'b0;
		model_hilo = '0;
		model_reg = '0;
		errors = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		run_test("mult", 0, 2, 0);
		run_test("madd_msub", 2, 4, 0);
		run_test("mul_div", 6, 3, 0);
		run_test("move", 9, 4, 0);
		run_test("dual_slot", 0, 13, 1);
		run_test("stall_flush", 0, 13, 2);
		repeat (4) @(posedge clk);
		$display("%0d tests, %0d operations, %0d errors", NUM_TESTS,
			NUM_TESTS * OPS_PER_TEST, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	a_hilo: assert property (@(posedge clk) disable iff (rst) commit_now |=> hilo == model_hilo)
		else begin
			errors++;
			$display("FAILED at %0t: hilo is %h, expected %h", $time, $sampled(hilo),
				$sampled(model_hilo));
		end

	a_reg: assert property (@(posedge clk) disable iff (rst)
		(commit_now && reg_due) |=> reg_o == model_reg)
		else begin
			errors++;
			$display("FAILED at %0t: reg_o is %h, expected %h", $time, $sampled(reg_o),
				$sampled(model_reg));
		end

	// No commit may slip through a stalled FINISH or a flush.
	a_hold: assert property (@(posedge clk) disable iff (rst)
		(flush || (in_finish && stall)) |=> hilo == hilo_prev)
		else begin
			errors++;
			$display("FAILED at %0t: hilo is %h, expected %h", $time, $sampled(hilo),
				$sampled(hilo_prev));
		end

	a_finish_low: assert property (@(posedge clk) disable iff (rst)
		(in_finish && stall) |=> !stall_req)
		else begin
			errors++;
			$display("FAILED at %0t: stall_req is %b, expected 0", $time, $sampled(stall_req));
		end

	a_idle_low: assert property (@(posedge clk) disable iff (rst) !pending |-> !stall_req)
		else begin
			errors++;
			$display("FAILED at %0t: stall_req is %b, expected 0", $time, $sampled(stall_req));
		end

endmodule
